// File: build.f
+incdir+.
tx_dma_pkg.sv
tx_huge_pages_addr.sv
tx_page_drain.sv
tx_dma_ctrl_top.sv
tb_tx_dma_ctrl.sv

// File: run_sim.sh
#!/usr/bin/env bash
# builds the tx dma control testbench with verilator and runs it
# exit status is nonzero when the simulation stops on an error

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/100ps -j 0 -f build.f \
    --top-module tb_tx_dma_ctrl -o tb_tx_dma_sim \
    && ./obj_dir/tb_tx_dma_sim \
    || { echo "tx dma simulation failed"; exit 1; }

// File: tb_tx_dma_ctrl.sv
////////////////////////////////////////////////////////////
// testbench of the tx dma control path
// random bar2 writes and junk tlps with trn back-pressure,
// slow read acks, descriptors checked against a model
////////////////////////////////////////////////////////////

`timescale 1ns/100ps

`include "tx_dma_settings.svh"

module tb_tx_dma_ctrl;

    localparam logic [31:0] seed   = 32'ha3d6af53;
    localparam int          rounds = 30;

    logic                  trn_clk;
    logic                  reset;
    tx_dma_pkg::trn_beat_u trn_rd;
    logic [7:0]            trn_rrem_n;
    logic                  trn_rsof_n;
    logic                  trn_reof_n;
    logic                  trn_rsrc_rdy_n;
    logic                  trn_rdst_rdy_n;
    logic [6:0]            trn_rbar_hit_n;
    tx_dma_pkg::rd_desc_t  rd_desc;
    logic                  rd_req;
    logic                  rd_ack;
    logic [63:0]           completed_buffer_address;

    logic [31:0]           stim_st;             // lfsr of the trn stimulus
    logic [31:0]           ack_st;              // lfsr of the ack responder
    int                    ack_dly;
    int                    ack_hold;
    logic [63:0]           model_addr [0:1];    // page bases as the driver set them
    logic [63:0]           model_cpl;
    tx_dma_pkg::rd_desc_t  exp_p1[$];           // expected chunks of page 1
    tx_dma_pkg::rd_desc_t  exp_p2[$];
    tx_dma_pkg::rd_desc_t  got_q[$];            // descriptors seen at req rise
    tx_dma_pkg::rd_desc_t  held;
    int                    rst_edges = 0;
    logic                  prev_req;
    logic                  prev_ack;            // ack as seen when req was launched
    logic                  in_hs;               // req/ack handshake open

    tx_dma_ctrl_top u_tx_dma_ctrl_top (
        .trn_clk                  (trn_clk),
        .reset                    (reset),
        .trn_rd                   (trn_rd),
        .trn_rrem_n               (trn_rrem_n),
        .trn_rsof_n               (trn_rsof_n),
        .trn_reof_n               (trn_reof_n),
        .trn_rsrc_rdy_n           (trn_rsrc_rdy_n),
        .trn_rdst_rdy_n           (trn_rdst_rdy_n),
        .trn_rbar_hit_n           (trn_rbar_hit_n),
        .rd_desc                  (rd_desc),
        .rd_req                   (rd_req),
        .rd_ack                   (rd_ack),
        .completed_buffer_address (completed_buffer_address)
    );

    always begin
        trn_clk = 1'b0;
        #4;
        trn_clk = 1'b1;
        #4;                                     // 8 ns period
    end

    ////////////////////////////////////////////////////////////
    // random numbers and result checks
    ////////////////////////////////////////////////////////////

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        lfsr_next = s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);  // galois taps 32,22,2,1
    endfunction

    function automatic logic [31:0] stim_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            stim_st = lfsr_next(stim_st);       // one step per bit
            v       = {v[30:0], stim_st[0]};
        end
        stim_bits = v;
    endfunction

    function automatic logic [31:0] ack_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            ack_st = lfsr_next(ack_st);
            v      = {v[30:0], ack_st[0]};
        end
        ack_bits = v;
    endfunction

    // byte 0 of the little endian value leads on the wire
    function automatic logic [31:0] le_dword(input logic [31:0] v);
        le_dword = {v[7:0], v[15:8], v[23:16], v[31:24]};
    endfunction

    task automatic abort_run();
        $display("Done: errors found");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic compare_desc(input tx_dma_pkg::rd_desc_t got,
                                input tx_dma_pkg::rd_desc_t exp, input string what);
        if (got !== exp) begin
            $display("[ERROR] %0t: %s, got addr %h qwords %0d last %b", $time, what,
                     got.addr, got.qwords, got.last);
            $display("[ERROR] %0t: expected addr %h qwords %0d last %b", $time,
                     exp.addr, exp.qwords, exp.last);
            abort_run();
        end
    endtask

    task automatic compare_addr(input logic [63:0] got, input logic [63:0] exp,
                                input string what);
        if (got !== exp) begin
            $display("[ERROR] %0t: %s, got %h expected %h", $time, what, got, exp);
            abort_run();
        end
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) begin
            @(posedge trn_clk);
            #1;
        end
    endtask

    ////////////////////////////////////////////////////////////
    // trn receive driver
    ////////////////////////////////////////////////////////////

    // holds one beat with random src and dst gaps until taken
    task automatic send_beat(input tx_dma_pkg::trn_beat_u beat, input logic sof,
                             input logic eof, input logic [7:0] rrem_n);
        tx_dma_pkg::trn_beat_u junk;
        logic                  src_gap;
        logic                  dst_gap;
        int                    tries;
        tries   = 0;
        src_gap = 1'b1;
        dst_gap = 1'b1;
        while (src_gap || dst_gap) begin
            src_gap        = (stim_bits(2) == 0);
            dst_gap        = (stim_bits(2) == 0);
            junk           = {stim_bits(32), stim_bits(32)};
            trn_rd         = src_gap ? junk : beat;     // garbage while not valid
            trn_rsof_n     = !sof;
            trn_reof_n     = !eof;
            trn_rrem_n     = rrem_n;
            trn_rsrc_rdy_n = src_gap;
            trn_rdst_rdy_n = dst_gap;
            @(posedge trn_clk);
            #1;
            tries++;
            if (tries > 100) begin
                $display("trn beat not accepted after 100 cycles at %0t", $time);
                abort_run();
            end
        end
        trn_rsrc_rdy_n = 1'b1;
    endtask

    // 3dw header tlp with ndata 0 for a read or 1 to 2 data dwords
    task automatic send_hdr3(input logic [6:0] fmt, input int bar, input int ndata,
                             input logic [5:0] ofs, input logic [31:0] dw0,
                             input logic [31:0] dw1);
        tx_dma_pkg::trn_beat_u hb;
        tx_dma_pkg::trn_beat_u ab;
        tx_dma_pkg::trn_beat_u db;
        hb                   = '0;
        hb.hdr.fmt_type      = fmt;
        hb.hdr.length        = (ndata == 2) ? 10'd2 : 10'd1;
        hb.hdr.requester_id  = 16'(stim_bits(16));
        hb.hdr.tag           = 8'(stim_bits(8));
        hb.hdr.first_be      = 4'hf;
        hb.hdr.last_be       = (ndata == 2) ? 4'hf : 4'h0;
        ab.adr.addr_hi       = 24'(stim_bits(24));
        ab.adr.offset        = ofs;
        ab.adr.addr_lo       = 2'b00;
        ab.adr.data          = dw0;
        db                   = {dw1, stim_bits(32)};    // lower dword unused
        trn_rbar_hit_n       = ~(7'b1 << bar);
        send_beat(hb, 1'b1, 1'b0, 8'h00);
        if (ndata == 2) begin
            send_beat(ab, 1'b0, 1'b0, 8'h00);
            send_beat(db, 1'b0, 1'b1, 8'h0f);
        end else begin
            send_beat(ab, 1'b0, 1'b1, (ndata == 1) ? 8'h00 : 8'h0f);
        end
    endtask

    task automatic send_mwr64(input logic [5:0] ofs);
        tx_dma_pkg::trn_beat_u hb;
        hb              = '0;
        hb.hdr.fmt_type = 7'b11_00000;          // 4dw header with data
        hb.hdr.length   = 10'd2;
        hb.hdr.first_be = 4'hf;
        hb.hdr.last_be  = 4'hf;
        trn_rbar_hit_n  = ~(7'b1 << `TX_REG_BAR);
        send_beat(hb, 1'b1, 1'b0, 8'h00);
        // register offset in address bits 7:2 of both dwords
        send_beat({24'(stim_bits(24)), ofs, 2'b00, 24'(stim_bits(24)), ofs, 2'b00},
                  1'b0, 1'b0, 8'h00);
        send_beat({stim_bits(32), stim_bits(32)}, 1'b0, 1'b1, 8'h00);
    endtask

    function automatic logic [5:0] valid_ofs();
        case (stim_bits(3) % 5)
            0:       valid_ofs = `TX_OFS_PAGE1_ADDR;
            1:       valid_ofs = `TX_OFS_PAGE2_ADDR;
            2:       valid_ofs = `TX_OFS_PAGE1_UNLOCK;
            3:       valid_ofs = `TX_OFS_PAGE2_UNLOCK;
            default: valid_ofs = `TX_OFS_CPL_BUF;
        endcase
    endfunction

    // traffic the register block must drop
    task automatic send_junk();
        int         bar;
        logic [5:0] ofs;
        case (stim_bits(2))
            0: begin
                bar = int'(stim_bits(3) % 6);
                if (bar >= `TX_REG_BAR) bar++;  // any bar but the registers
                send_hdr3(`TX_MWR32_FMT_TYPE, bar, 2, valid_ofs(), stim_bits(32), stim_bits(32));
            end
            1: send_hdr3(7'b00_00000, `TX_REG_BAR, 0, valid_ofs(), stim_bits(32),
                         32'h0);                // mem read with garbage in the lower dword
            2: send_mwr64(valid_ofs());
            default: begin
                ofs = (stim_bits(1) != 0) ? {2'b11, 4'(stim_bits(4))} : {1'b0, 5'(stim_bits(5))};
                send_hdr3(`TX_MWR32_FMT_TYPE, `TX_REG_BAR, 2, ofs, stim_bits(32), stim_bits(32));
            end
        endcase
    endtask

    task automatic write_reg(input logic [5:0] ofs, input logic [63:0] value);
        send_hdr3(`TX_MWR32_FMT_TYPE, `TX_REG_BAR, 2, ofs, le_dword(value[31:0]),
                  le_dword(value[63:32]));
    endtask

    ////////////////////////////////////////////////////////////
    // reference model of the drain
    ////////////////////////////////////////////////////////////

    task automatic unlock_page(input int p, input logic [31:0] size);
        tx_dma_pkg::rd_desc_t d;
        logic [31:0]          done_q;
        logic [31:0]          q;
        send_hdr3(`TX_MWR32_FMT_TYPE, `TX_REG_BAR, 1,
                  (p == 0) ? `TX_OFS_PAGE1_UNLOCK : `TX_OFS_PAGE2_UNLOCK, le_dword(size), 32'h0);
        done_q = 32'd0;
        while (done_q < size) begin             // one chunk per descriptor
            q        = (size - done_q > 32'(`TX_CHUNK_QWORDS)) ? 32'(`TX_CHUNK_QWORDS)
                                                               : size - done_q;
            d.addr   = model_addr[p] + 64'(done_q) * 64'd8;
            d.qwords = tx_dma_pkg::desc_qw_t'(q);
            d.last   = (done_q + q == size);
            if (p == 0) exp_p1.push_back(d);
            else exp_p2.push_back(d);
            done_q += q;
        end
    endtask

    task automatic run_round(input logic zero_page1);
        tx_dma_pkg::rd_desc_t exp_all[$];
        logic [63:0]          value;
        logic [31:0]          size;
        int                   order;
        int                   p;
        int                   cnt;
        exp_p1.delete();
        exp_p2.delete();
        order = int'(stim_bits(1));             // which page is unlocked first
        for (int k = 0; k < 2; k++) begin
            p = k ^ order;
            if (stim_bits(2) == 0) send_junk();
            if (stim_bits(2) != 0) begin
                value = {stim_bits(32), 29'(stim_bits(29)), 3'b000};
                write_reg((p == 0) ? `TX_OFS_PAGE1_ADDR : `TX_OFS_PAGE2_ADDR, value);
                model_addr[p] = value;
            end
            size = (stim_bits(3) == 0 || (zero_page1 && p == 0)) ? 32'd0 : stim_bits(7);
            unlock_page(p, size);
            if (stim_bits(2) == 0) send_junk();
        end
        if (stim_bits(1) != 0) begin
            value = {stim_bits(32), stim_bits(32)};
            write_reg(`TX_OFS_CPL_BUF, value);
            model_cpl = value;
        end
        foreach (exp_p1[i]) exp_all.push_back(exp_p1[i]);   // page 1 always drains first
        foreach (exp_p2[i]) exp_all.push_back(exp_p2[i]);
        cnt = 0;
        while (got_q.size() < exp_all.size()) begin
            @(posedge trn_clk);
            #1;
            cnt++;
            if (cnt > 5000) begin
                $display("read descriptors missing after 5000 cycles at %0t", $time);
                abort_run();
            end
        end
        idle_cycles(64);                        // lets frees finish and strays show up
        if (got_q.size() != exp_all.size()) begin
            $display("[ERROR] %0t: %0d read descriptors, expected %0d", $time,
                     got_q.size(), exp_all.size());
            abort_run();
        end
        foreach (exp_all[i]) compare_desc(got_q[i], exp_all[i], "read descriptor");
        compare_addr(completed_buffer_address, model_cpl, "completion buffer address");
        got_q.delete();
    endtask

    ////////////////////////////////////////////////////////////
    // ack responder and handshake monitor of the read engine side
    ////////////////////////////////////////////////////////////

    initial begin
        rd_ack   = 1'b0;
        ack_st   = seed;
        ack_dly  = 0;
        ack_hold = 0;
        forever begin
            @(posedge trn_clk);
            #1;
            if (reset) begin
                rd_ack  = 1'b0;
                ack_dly = 0;
            end else if (!rd_ack && rd_req) begin
                if (ack_dly == 0) begin
                    rd_ack   = 1'b1;
                    ack_dly  = int'(ack_bits(3));   // delay before dropping ack
                    ack_hold = 0;
                end else begin
                    ack_dly--;
                end
            end else if (rd_ack && !rd_req) begin
                if (ack_dly == 0) begin
                    rd_ack  = 1'b0;
                    ack_dly = int'(ack_bits(3));    // delay before the next ack
                end else begin
                    ack_dly--;
                end
            end else if (rd_ack) begin
                ack_hold++;
                if (ack_hold > 50) begin
                    $display("rd_req still high 50 cycles after rd_ack at %0t", $time);
                    abort_run();
                end
            end
        end
    end

    always @(posedge trn_clk) begin
        if (reset) begin
            if (rst_edges > 0 && rd_req !== 1'b0) begin     // first edge loads the reset
                $display("[ERROR] %0t: rd_req not low during reset", $time);
                abort_run();
            end
            rst_edges++;
            prev_req = 1'b0;
            prev_ack = 1'b0;
            in_hs    = 1'b0;
        end else begin
            if (rd_req && !prev_req) begin
                if (prev_ack) begin
                    $display("[ERROR] %0t: rd_req rose while rd_ack was high", $time);
                    abort_run();
                end
                held  = rd_desc;
                in_hs = 1'b1;
                got_q.push_back(rd_desc);
            end else if (in_hs) begin
                compare_desc(rd_desc, held, "rd_desc changed during handshake");
                if (!rd_req && !rd_ack) in_hs = 1'b0;
            end
            prev_req = rd_req;
            prev_ack = rd_ack;
        end
    end

    ////////////////////////////////////////////////////////////
    // main sequence
    ////////////////////////////////////////////////////////////

    initial begin
        stim_st        = seed;
        reset          = 1'b1;
        trn_rd         = '0;
        trn_rrem_n     = 8'h00;
        trn_rsof_n     = 1'b1;
        trn_reof_n     = 1'b1;
        trn_rsrc_rdy_n = 1'b1;
        trn_rdst_rdy_n = 1'b1;
        trn_rbar_hit_n = 7'h7f;
        model_addr[0]  = 64'd0;                 // registers clear in reset
        model_addr[1]  = 64'd0;
        model_cpl      = 64'd0;
        repeat (8) @(posedge trn_clk);
        #1;
        reset = 1'b0;
        idle_cycles(4);
        compare_addr(completed_buffer_address, 64'd0, "completion buffer after reset");
        for (int r = 0; r < rounds; r++) begin
            run_round(r == 1);                  // round 1 has an empty page 1
        end
        $display("Done: no errors");
        $finish;
    end

endmodule

// File: tx_dma_ctrl_top.sv
////////////////////////////////////////////////////////////
// tx dma control path, register block plus drain engine
// sits on the trn rx stream, emits read descriptors
////////////////////////////////////////////////////////////

`timescale 1ns/100ps

module tx_dma_ctrl_top (
    input  logic                   trn_clk,
    input  logic                   reset,

    input  tx_dma_pkg::trn_beat_u  trn_rd,
    input  logic [7:0]             trn_rrem_n,
    input  logic                   trn_rsof_n,
    input  logic                   trn_reof_n,
    input  logic                   trn_rsrc_rdy_n,
    input  logic                   trn_rdst_rdy_n,
    input  logic [6:0]             trn_rbar_hit_n,

    output tx_dma_pkg::rd_desc_t   rd_desc,
    output logic                   rd_req,
    input  logic                   rd_ack,
    output logic [63:0]            completed_buffer_address
);

    tx_dma_pkg::huge_page_t page_1;             // slot state to the drain engine
    tx_dma_pkg::huge_page_t page_2;
    logic                   page_free_1;        // release pulses back
    logic                   page_free_2;

    tx_huge_pages_addr u_tx_huge_pages_addr (
        .trn_clk                  (trn_clk),
        .reset                    (reset),
        .trn_rd                   (trn_rd),
        .trn_rrem_n               (trn_rrem_n),
        .trn_rsof_n               (trn_rsof_n),
        .trn_reof_n               (trn_reof_n),
        .trn_rsrc_rdy_n           (trn_rsrc_rdy_n),
        .trn_rdst_rdy_n           (trn_rdst_rdy_n),
        .trn_rbar_hit_n           (trn_rbar_hit_n),
        .page_free_1              (page_free_1),
        .page_free_2              (page_free_2),
        .page_1                   (page_1),
        .page_2                   (page_2),
        .completed_buffer_address (completed_buffer_address)
    );

    tx_page_drain u_tx_page_drain (
        .trn_clk     (trn_clk),
        .reset       (reset),
        .page_1      (page_1),
        .page_2      (page_2),
        .page_free_1 (page_free_1),
        .page_free_2 (page_free_2),
        .rd_desc     (rd_desc),
        .rd_req      (rd_req),
        .rd_ack      (rd_ack)
    );

endmodule

// File: tx_dma_pkg.sv
////////////////////////////////////////////////////////////
// types shared by the tx dma control path
// trn beat views, huge page slot and read descriptor
// referenced by scoped names, never imported
////////////////////////////////////////////////////////////

`include "tx_dma_settings.svh"

package tx_dma_pkg;

    ////////////////////////////////////////////////////////////
    // trn receive beat
    ////////////////////////////////////////////////////////////

    // first beat of a tlp, header dw0 in the upper half
    typedef struct packed {
        logic        rsvd_63;           // reserved
        logic [6:0]  fmt_type;          // format and type
        logic        rsvd_55;           // reserved
        logic [2:0]  tc;                // traffic class
        logic [3:0]  rsvd_51;           // reserved
        logic        td;                // digest present
        logic        ep;                // poisoned
        logic [1:0]  attr;              // ordering attributes
        logic [1:0]  rsvd_43;           // reserved
        logic [9:0]  length;            // payload in dwords
        logic [15:0] requester_id;      // bus, device, function
        logic [7:0]  tag;               // request tag
        logic [3:0]  last_be;           // last dw byte enables
        logic [3:0]  first_be;          // first dw byte enables
    } trn_hdr_t;

    // second beat of a 3dw write, address then first data dword
    typedef struct packed {
        logic [23:0] addr_hi;           // address bits 31:8
        logic [5:0]  offset;            // address bits 7:2, register select
        logic [1:0]  addr_lo;           // dword aligned, zero
        logic [31:0] data;              // first data dword, little endian
    } trn_adr_t;

    // same 64-bit word, decoded by beat position
    typedef union packed {
        trn_hdr_t hdr;                  // sof beat
        trn_adr_t adr;                  // beat after sof
    } trn_beat_u;

    ////////////////////////////////////////////////////////////
    // page slots and read requests
    ////////////////////////////////////////////////////////////

    typedef struct packed {
        logic [63:0] addr;              // page base, byte address
        logic [31:0] qwords;            // filled size in qwords
        logic        ready;             // unlocked, owned by the card
    } huge_page_t;

    // qword count of one descriptor, 0 to chunk size
    typedef logic [$clog2(`TX_CHUNK_QWORDS + 1)-1:0] desc_qw_t;

    typedef struct packed {
        logic [63:0] addr;              // start byte address
        desc_qw_t    qwords;            // qwords to read
        logic        last;              // final chunk of the page
    } rd_desc_t;

endpackage

// File: tx_dma_settings.svh
////////////////////////////////////////////////////////////
// constants of the tx dma control path
// bar select, tlp code, register map and chunk size
// include wherever one of these values is needed
////////////////////////////////////////////////////////////

`ifndef TX_DMA_SETTINGS_SVH
`define TX_DMA_SETTINGS_SVH

////////////////////////////////////////////////////////////
// pcie side
////////////////////////////////////////////////////////////

`define TX_REG_BAR 2                       // bar hit bit of the register space
`define TX_MWR32_FMT_TYPE 7'b10_00000      // 3dw header with data, memory write

////////////////////////////////////////////////////////////
// register offsets, address bits 7:2
////////////////////////////////////////////////////////////

`define TX_OFS_PAGE1_ADDR 6'd32            // base of huge page 1
`define TX_OFS_PAGE2_ADDR 6'd34            // base of huge page 2
`define TX_OFS_PAGE1_UNLOCK 6'd40          // size of page 1, hands it over
`define TX_OFS_PAGE2_UNLOCK 6'd41          // size of page 2, hands it over
`define TX_OFS_CPL_BUF 6'd44               // completion buffer address

// qwords per read descriptor
`define TX_CHUNK_QWORDS 16

`endif

// File: tx_huge_pages_addr.sv
////////////////////////////////////////////////////////////
// register block of the tx dma, snoops the trn rx stream
// decodes bar2 32-bit memory writes into page addresses,
// page sizes, ready flags and the completion buffer address
////////////////////////////////////////////////////////////

`timescale 1ns/100ps

`include "tx_dma_settings.svh"

module tx_huge_pages_addr (
    input  logic                   trn_clk,
    input  logic                   reset,

    input  tx_dma_pkg::trn_beat_u  trn_rd,
    input  logic [7:0]             trn_rrem_n,
    input  logic                   trn_rsof_n,
    input  logic                   trn_reof_n,
    input  logic                   trn_rsrc_rdy_n,
    input  logic                   trn_rdst_rdy_n,
    input  logic [6:0]             trn_rbar_hit_n,

    input  logic                   page_free_1,
    input  logic                   page_free_2,
    output tx_dma_pkg::huge_page_t page_1,
    output tx_dma_pkg::huge_page_t page_2,
    output logic [63:0]            completed_buffer_address
);

    typedef enum logic [1:0] {
        st_idle,                                // wait for a bar2 mwr32 header
        st_offset,                              // address beat, pick the register
        st_data_hi                              // second data dword
    } rx_state_e;

    localparam logic [1:0] tgt_page1 = 2'd0;
    localparam logic [1:0] tgt_page2 = 2'd1;
    localparam logic [1:0] tgt_cpl   = 2'd2;

    rx_state_e   state;
    logic [1:0]  wr_tgt;                        // register hit by the 64-bit write
    logic [31:0] aux_dw;                        // first data dword, still swapped
    logic [1:0]  page_unlock;                   // one cycle, bit 0 is page 1
    logic [1:0]  page_free;
    logic [63:0] page_addr [0:1];
    logic [31:0] page_qwords [0:1];
    logic [1:0]  page_ready;
    logic        beat_ok;
    logic        lo_dw_valid;
    logic [63:0] wr_value;

    // driver data is little endian on the wire
    function automatic logic [31:0] swap32(input logic [31:0] dw);
        swap32 = {dw[7:0], dw[15:8], dw[23:16], dw[31:24]};
    endfunction

    assign beat_ok     = !trn_rsrc_rdy_n && !trn_rdst_rdy_n;            // beat taken by user
    assign lo_dw_valid = trn_reof_n || (trn_rrem_n[3:0] == 4'h0);       // lower dword present
    assign wr_value    = {swap32(trn_rd[63:32]), swap32(aux_dw)};       // hi dw from this beat
    assign page_free   = {page_free_2, page_free_1};

    ////////////////////////////////////////////////////////////
    // tlp reception
    ////////////////////////////////////////////////////////////

    always_ff @(posedge trn_clk) begin
        if (reset) begin
            state                    <= st_idle;
            page_unlock              <= 2'b00;
            page_addr[0]             <= 64'd0;
            page_addr[1]             <= 64'd0;
            completed_buffer_address <= 64'd0;
        end else begin
            page_unlock <= 2'b00;                   // pulse only
            case (state)
                st_idle: begin
                    if (beat_ok && !trn_rsof_n && trn_reof_n &&
                        !trn_rbar_hit_n[`TX_REG_BAR] &&
                        (trn_rd.hdr.fmt_type == `TX_MWR32_FMT_TYPE)) begin
                        state <= st_offset;         // reads, mwr64, other bars dropped
                    end
                end

                st_offset: begin
                    if (beat_ok) begin
                        aux_dw <= trn_rd.adr.data;
                        state  <= st_idle;          // unless a data beat follows
                        case (trn_rd.adr.offset)
                            `TX_OFS_PAGE1_ADDR: begin
                                wr_tgt <= tgt_page1;
                                if (trn_reof_n) state <= st_data_hi;
                            end
                            `TX_OFS_PAGE2_ADDR: begin
                                wr_tgt <= tgt_page2;
                                if (trn_reof_n) state <= st_data_hi;
                            end
                            `TX_OFS_CPL_BUF: begin
                                wr_tgt <= tgt_cpl;
                                if (trn_reof_n) state <= st_data_hi;
                            end
                            `TX_OFS_PAGE1_UNLOCK: page_unlock[0] <= lo_dw_valid;
                            `TX_OFS_PAGE2_UNLOCK: page_unlock[1] <= lo_dw_valid;
                            default: ;              // unknown register, ignored
                        endcase
                    end
                end

                st_data_hi: begin
                    if (beat_ok) begin
                        state <= st_idle;
                        case (wr_tgt)
                            tgt_page1: page_addr[0]             <= wr_value;
                            tgt_page2: page_addr[1]             <= wr_value;
                            default:   completed_buffer_address <= wr_value;
                        endcase
                    end
                end

                default: state <= st_idle;
            endcase
        end
    end

    ////////////////////////////////////////////////////////////
    // page status, unlock wins over free
    ////////////////////////////////////////////////////////////

    always_ff @(posedge trn_clk) begin
        if (reset) begin
            page_ready <= 2'b00;
        end else begin
            for (int i = 0; i < 2; i++) begin
                if (page_unlock[i]) begin
                    page_ready[i]  <= 1'b1;
                    page_qwords[i] <= swap32(aux_dw);   // size held in aux since the unlock
                end else if (page_free[i]) begin
                    page_ready[i] <= 1'b0;              // drain engine is done with it
                end
            end
        end
    end

    assign page_1 = '{addr: page_addr[0], qwords: page_qwords[0], ready: page_ready[0]};
    assign page_2 = '{addr: page_addr[1], qwords: page_qwords[1], ready: page_ready[1]};

endmodule

// File: tx_page_drain.sv
////////////////////////////////////////////////////////////
// page drain engine of the tx dma
// walks page 1 and page 2 in turn, one read descriptor per
// chunk over a four-phase req/ack, then frees the page
////////////////////////////////////////////////////////////

`timescale 1ns/100ps

`include "tx_dma_settings.svh"

module tx_page_drain (
    input  logic                   trn_clk,
    input  logic                   reset,

    input  tx_dma_pkg::huge_page_t page_1,
    input  tx_dma_pkg::huge_page_t page_2,
    output logic                   page_free_1,
    output logic                   page_free_2,

    output tx_dma_pkg::rd_desc_t   rd_desc,
    output logic                   rd_req,
    input  logic                   rd_ack
);

    typedef enum logic [1:0] {
        st_wait_page,                           // current page not yet unlocked
        st_issue,                               // build next descriptor
        st_req,                                 // req high, wait ack
        st_release                              // req low, wait ack low
    } drain_state_e;

    localparam int unsigned chunk_qwords = `TX_CHUNK_QWORDS;

    drain_state_e           state;
    logic                   cur_page;           // 0 is page 1
    tx_dma_pkg::huge_page_t cur;
    logic [63:0]            next_addr;          // start of the next chunk
    logic [31:0]            left_q;             // qwords not yet requested
    tx_dma_pkg::desc_qw_t   chunk_qw;
    logic                   chunk_last;

    assign cur = cur_page ? page_2 : page_1;

    // smaller of chunk size and what is left
    assign chunk_qw   = (left_q < 32'(chunk_qwords)) ? tx_dma_pkg::desc_qw_t'(left_q)
                                                     : tx_dma_pkg::desc_qw_t'(chunk_qwords);
    assign chunk_last = (left_q <= 32'(chunk_qwords));

    ////////////////////////////////////////////////////////////
    // drain fsm
    ////////////////////////////////////////////////////////////

    always_ff @(posedge trn_clk) begin
        if (reset) begin
            state       <= st_wait_page;
            cur_page    <= 1'b0;                // page 1 goes first
            rd_req      <= 1'b0;
            page_free_1 <= 1'b0;
            page_free_2 <= 1'b0;
        end else begin
            page_free_1 <= 1'b0;                // pulses
            page_free_2 <= 1'b0;
            case (state)
                st_wait_page: begin
                    if (cur.ready) begin
                        if (cur.qwords == 32'd0) begin
                            page_free_1 <= !cur_page;   // empty page, hand straight back
                            page_free_2 <= cur_page;
                            cur_page    <= !cur_page;
                        end else begin
                            next_addr <= cur.addr;
                            left_q    <= cur.qwords;
                            state     <= st_issue;
                        end
                    end
                end

                st_issue: begin
                    rd_desc.addr   <= next_addr;
                    rd_desc.qwords <= chunk_qw;
                    rd_desc.last   <= chunk_last;
                    left_q         <= left_q - 32'(chunk_qw);
                    next_addr      <= next_addr + 64'({chunk_qw, 3'b000});   // 8 bytes a qword
                    rd_req         <= 1'b1;             // desc and req change together
                    state          <= st_req;
                end

                st_req: begin
                    if (rd_ack) begin
                        rd_req <= 1'b0;
                        state  <= st_release;
                    end
                end

                st_release: begin
                    if (!rd_ack) begin                  // handshake closed
                        if (rd_desc.last) begin
                            page_free_1 <= !cur_page;
                            page_free_2 <= cur_page;
                            cur_page    <= !cur_page;   // strict alternation
                            state       <= st_wait_page;
                        end else begin
                            state <= st_issue;
                        end
                    end
                end

                default: state <= st_wait_page;
            endcase
        end
    end

endmodule
